/* src.f */
logic/idma_width_pkg.sv
logic/idma_ctrl_pkg.sv
logic/idma_burst_splitter.sv
logic/idma_rw_coupler.sv
logic/idma_legalizer_top.sv
tb/tb_idma_legalizer.sv

/* tb/tb_idma_legalizer.sv */
// ------------------------------
// Directed tests with PageBytes 256, bursts compared against a model
// A timed out wait counts as an error and the run goes on
// ------------------------------
`timescale 1ns/1ps

module tb_idma_legalizer
    import idma_width_pkg::*;
();

    localparam int unsigned PageBytes = 256;
    // Cycles allowed for one wait loop
    localparam int unsigned Timeout = 500;

    // ------------------------------
    // DUT signals
    // ------------------------------
    logic      clk;
    logic      arst_n;
    logic      req_valid;
    addr_t     req_src_addr;
    addr_t     req_dst_addr;
    len_t      req_len;
    logic      req_decouple;
    logic      req_ready;
    logic      r_valid;
    addr_t     r_addr;
    page_len_t r_len;
    logic      r_ready;
    logic      w_valid;
    addr_t     w_addr;
    page_len_t w_len;
    logic      w_last;
    logic      w_ready;
    logic      flush;
    logic      kill;
    logic      r_busy;
    logic      w_busy;

    // Expected bursts, filled by the model
    addr_t       exp_r_addr[$];
    int unsigned exp_r_len[$];
    addr_t       exp_w_addr[$];
    int unsigned exp_w_len[$];

    int unsigned err_cnt;
    int unsigned chk_cnt;
    logic [31:0] lfsr;

    idma_legalizer_top #(
        .PageBytes      (PageBytes)
    ) dut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .req_valid_i    (req_valid),
        .req_src_addr_i (req_src_addr),
        .req_dst_addr_i (req_dst_addr),
        .req_len_i      (req_len),
        .req_decouple_i (req_decouple),
        .req_ready_o    (req_ready),
        .r_valid_o      (r_valid),
        .r_addr_o       (r_addr),
        .r_len_o        (r_len),
        .r_ready_i      (r_ready),
        .w_valid_o      (w_valid),
        .w_addr_o       (w_addr),
        .w_len_o        (w_len),
        .w_last_o       (w_last),
        .w_ready_i      (w_ready),
        .flush_i        (flush),
        .kill_i         (kill),
        .r_busy_o       (r_busy),
        .w_busy_o       (w_busy)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        chk_cnt++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s exp 0x%h got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        chk_cnt++;
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", msg);
            err_cnt++;
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // Reference burst rule, fills the expected queues
    task automatic run_model(input addr_t src, input addr_t dst, input len_t len,
                             input logic dec);
        addr_t       ra;
        addr_t       wa;
        int unsigned rem_r;
        int unsigned rem_w;
        int unsigned dist_r;
        int unsigned dist_w;
        int unsigned bl;
        exp_r_addr.delete();
        exp_r_len.delete();
        exp_w_addr.delete();
        exp_w_len.delete();
        ra = src;
        wa = dst;
        rem_r = len;
        rem_w = len;
        while ((rem_r != 0) || (rem_w != 0)) begin
            dist_r = PageBytes - (ra % PageBytes);
            dist_w = PageBytes - (wa % PageBytes);
            // Coupled: both sides take the nearer boundary
            if (!dec) begin
                dist_r = (dist_r < dist_w) ? dist_r : dist_w;
                dist_w = dist_r;
            end
            if (rem_r != 0) begin
                bl = (rem_r < dist_r) ? rem_r : dist_r;
                exp_r_addr.push_back(ra);
                exp_r_len.push_back(bl);
                ra += bl;
                rem_r -= bl;
            end
            if (rem_w != 0) begin
                bl = (rem_w < dist_w) ? rem_w : dist_w;
                exp_w_addr.push_back(wa);
                exp_w_len.push_back(bl);
                wa += bl;
                rem_w -= bl;
            end
        end
    endtask

    // Hold the request until req_ready shows, handshake at the next edge
    task automatic accept_req(input addr_t src, input addr_t dst, input len_t len,
                              input logic dec);
        int unsigned cyc;
        logic        done;
        done = 1'b0;
        cyc  = 0;
        while (!done && (cyc < Timeout)) begin
            @(negedge clk);
            req_valid    = 1'b1;
            req_src_addr = src;
            req_dst_addr = dst;
            req_len      = len;
            req_decouple = dec;
            r_ready      = 1'b1;
            w_ready      = 1'b1;
            flush        = 1'b0;
            kill         = 1'b0;
            #2;
            done = req_ready;
            cyc++;
        end
        expect_true(done, "request not accepted before timeout");
        run_model(src, dst, len, dec);
    endtask

    // Take bursts until the queues drain, or until max_w write bursts if nonzero
    task automatic collect_bursts(input logic dec, input logic rnd,
                                  input int unsigned flush_from, input int unsigned flush_to,
                                  input int unsigned max_w, input len_t len);
        int unsigned cyc;
        int unsigned w_cnt;
        int unsigned r_sum;
        int unsigned w_sum;
        logic        r_hs;
        logic        w_hs;
        logic        r_hold;
        logic        w_hold;
        addr_t       hold_r_addr;
        addr_t       hold_w_addr;
        page_len_t   hold_r_len;
        page_len_t   hold_w_len;
        cyc    = 0;
        w_cnt  = 0;
        r_sum  = 0;
        w_sum  = 0;
        r_hold = 1'b0;
        w_hold = 1'b0;
        while (((exp_r_len.size() != 0) || (exp_w_len.size() != 0))
               && ((max_w == 0) || (w_cnt < max_w)) && (cyc < Timeout)) begin
            @(negedge clk);
            req_valid = 1'b0;
            flush     = (cyc >= flush_from) && (cyc < flush_to);
            r_ready   = rnd ? lfsr_bit() : 1'b1;
            w_ready   = rnd ? lfsr_bit() : 1'b1;
            #2;
            // A stalled burst keeps address and length
            if (r_hold) begin
                compare_value("r_addr_o", hold_r_addr, r_addr);
                compare_value("r_len_o", hold_r_len, r_len);
            end
            if (w_hold) begin
                compare_value("w_addr_o", hold_w_addr, w_addr);
                compare_value("w_len_o", hold_w_len, w_len);
            end
            if (flush) begin
                expect_true(!r_valid && !w_valid && !req_ready,
                            "valid or req_ready high during flush");
            end
            r_hs = r_valid && r_ready;
            w_hs = w_valid && w_ready;
            if (!dec) begin
                expect_true(r_hs == w_hs, "read and write bursts not handed over together");
            end
            if (r_hs && (exp_r_len.size() == 0)) begin
                expect_true(1'b0, "read burst beyond the expected ones");
            end else if (r_hs) begin
                compare_value("r_addr_o", exp_r_addr.pop_front(), r_addr);
                compare_value("r_len_o", exp_r_len.pop_front(), r_len);
                r_sum += r_len;
            end
            if (w_hs && (exp_w_len.size() == 0)) begin
                expect_true(1'b0, "write burst beyond the expected ones");
            end else if (w_hs) begin
                compare_value("w_last_o", exp_w_len.size() == 1, w_last);
                compare_value("w_addr_o", exp_w_addr.pop_front(), w_addr);
                compare_value("w_len_o", exp_w_len.pop_front(), w_len);
                w_sum += w_len;
                w_cnt++;
            end
            r_hold      = r_busy && !r_hs;
            w_hold      = w_busy && !w_hs;
            hold_r_addr = r_addr;
            hold_r_len  = r_len;
            hold_w_addr = w_addr;
            hold_w_len  = w_len;
            cyc++;
        end
        if ((max_w == 0) || (w_cnt < max_w)) begin
            expect_true((exp_r_len.size() == 0) && (exp_w_len.size() == 0),
                        "timeout while waiting for bursts");
        end
        // Lengths of each side add up to the transfer
        if (max_w == 0) begin
            compare_value("r_len_o sum", len, r_sum);
            compare_value("w_len_o sum", len, w_sum);
        end
    endtask

    // One edge after the final burst both splitters are idle
    task automatic confirm_idle();
        @(negedge clk);
        #2;
        expect_true(!r_busy && !w_busy, "splitter still busy after its final burst");
    endtask

    // Complete transfer with a given ready pattern
    task automatic full_transfer(input addr_t src, input addr_t dst, input len_t len,
                                 input logic dec, input logic rnd);
        accept_req(src, dst, len, dec);
        collect_bursts(dec, rnd, 0, 0, 0, len);
        confirm_idle();
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic single_page_transfer();
        full_transfer(32'h0000_1000, 32'h0000_2010, 64, 1'b0, 1'b0);
    endtask

    task automatic decoupled_split();
        full_transfer(32'h0000_10F0, 32'h0000_2037, 700, 1'b1, 1'b0);
    endtask

    task automatic coupled_pairs();
        full_transfer(32'h0001_0010, 32'h0002_00A0, 600, 1'b0, 1'b0);
    endtask

    task automatic random_ready_stress();
        full_transfer(32'h0000_4004, 32'h0000_63C0, 1200, 1'b0, 1'b1);
        full_transfer(32'h0000_70FF, 32'h0000_8001, 777, 1'b1, 1'b1);
    endtask

    // Flush for four cycles in the middle of a transfer
    task automatic flush_pause();
        accept_req(32'h0000_9040, 32'h0000_A0C8, 900, 1'b1);
        collect_bursts(1'b1, 1'b0, 2, 6, 0, 900);
        confirm_idle();
        // Idle with both readies high, only flush keeps req_ready low
        @(negedge clk);
        flush   = 1'b1;
        r_ready = 1'b1;
        w_ready = 1'b1;
        #2;
        expect_true(!req_ready, "req_ready high during flush while idle");
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic kill_restart();
        accept_req(32'h0000_3010, 32'h0000_5080, 1000, 1'b1);
        collect_bursts(1'b1, 1'b0, 0, 0, 2, 1000);
        @(negedge clk);
        kill    = 1'b1;
        r_ready = 1'b0;
        w_ready = 1'b0;
        @(negedge clk);
        kill = 1'b0;
        #2;
        expect_true(!r_busy && !w_busy, "busy still high after kill");
        // Fresh transfer after the kill
        full_transfer(32'h0000_B0E0, 32'h0000_C010, 500, 1'b0, 1'b0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        err_cnt      = 0;
        chk_cnt      = 0;
        lfsr         = 32'd82583;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req_src_addr = '0;
        req_dst_addr = '0;
        req_len      = '0;
        req_decouple = 1'b0;
        r_ready      = 1'b0;
        w_ready      = 1'b0;
        flush        = 1'b0;
        kill         = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #2;
        expect_true(!r_valid && !w_valid && !req_ready && !r_busy && !w_busy,
                    "outputs not idle after reset");
        single_page_transfer();
        decoupled_split();
        coupled_pairs();
        random_ready_stress();
        flush_pause();
        kill_restart();
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* logic/idma_legalizer_top.sv */
// ------------------------------
// PageBytes must be a power of two from 64 to 4096
// Zero length transfers are not legal
// ------------------------------
`timescale 1ns/1ps

module idma_legalizer_top
    import idma_width_pkg::*;
#(
    // Page size in bytes for both sides
    parameter int unsigned PageBytes = 256
) (
    input  logic      clk_i,
    input  logic      arst_n_i,

    // 1D transfer request
    input  logic      req_valid_i,
    input  addr_t     req_src_addr_i,
    input  addr_t     req_dst_addr_i,
    input  len_t      req_len_i,
    input  logic      req_decouple_i,
    output logic      req_ready_o,

    // Read bursts
    output logic      r_valid_o,
    output addr_t     r_addr_o,
    output page_len_t r_len_o,
    input  logic      r_ready_i,

    // Write bursts
    output logic      w_valid_o,
    output addr_t     w_addr_o,
    output page_len_t w_len_o,
    output logic      w_last_o,
    input  logic      w_ready_i,

    // Control
    input  logic      flush_i,
    input  logic      kill_i,

    // Status
    output logic      r_busy_o,
    output logic      w_busy_o
);

    // ------------------------------
    // Splitter to coupler
    // ------------------------------
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    logic      r_done;
    logic      w_done;

    // Coupler to splitters
    page_len_t r_possible;
    page_len_t w_possible;
    logic      r_advance;
    logic      w_advance;
    logic      load;
    logic      clear;

    // Final write burst of the transfer
    assign w_last_o = w_done;

    // ------------------------------
    // Read side
    // ------------------------------
    idma_burst_splitter #(
        .PageBytes     (PageBytes)
    ) u_read_splitter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .load_i        (load),
        .advance_i     (r_advance),
        .clear_i       (clear),
        .start_addr_i  (req_src_addr_i),
        .start_len_i   (req_len_i),
        .possible_i    (r_possible),
        .bytes_to_pb_o (r_bytes_to_pb),
        .done_o        (r_done),
        .burst_addr_o  (r_addr_o),
        .burst_len_o   (r_len_o),
        .busy_o        (r_busy_o)
    );

    // ------------------------------
    // Write side
    // ------------------------------
    idma_burst_splitter #(
        .PageBytes     (PageBytes)
    ) u_write_splitter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .load_i        (load),
        .advance_i     (w_advance),
        .clear_i       (clear),
        .start_addr_i  (req_dst_addr_i),
        .start_len_i   (req_len_i),
        .possible_i    (w_possible),
        .bytes_to_pb_o (w_bytes_to_pb),
        .done_o        (w_done),
        .burst_addr_o  (w_addr_o),
        .burst_len_o   (w_len_o),
        .busy_o        (w_busy_o)
    );

    // ------------------------------
    // Coupling and flow control
    // ------------------------------
    idma_rw_coupler u_coupler (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .req_valid_i     (req_valid_i),
        .req_decouple_i  (req_decouple_i),
        .req_ready_o     (req_ready_o),
        .r_ready_i       (r_ready_i),
        .w_ready_i       (w_ready_i),
        .flush_i         (flush_i),
        .kill_i          (kill_i),
        .r_bytes_to_pb_i (r_bytes_to_pb),
        .r_done_i        (r_done),
        .r_active_i      (r_busy_o),
        .w_bytes_to_pb_i (w_bytes_to_pb),
        .w_done_i        (w_done),
        .w_active_i      (w_busy_o),
        .r_valid_o       (r_valid_o),
        .w_valid_o       (w_valid_o),
        .r_advance_o     (r_advance),
        .w_advance_o     (w_advance),
        .load_o          (load),
        .clear_o         (clear),
        .r_possible_o    (r_possible),
        .w_possible_o    (w_possible)
    );

endmodule

/* logic/idma_rw_coupler.sv */
// ------------------------------
// Mode is sampled at acceptance and holds for the whole transfer
// In coupled mode each valid also waits for the other side's ready
// ------------------------------
`timescale 1ns/1ps

module idma_rw_coupler
    import idma_width_pkg::*;
    import idma_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,

    // Request side
    input  logic      req_valid_i,
    input  logic      req_decouple_i,
    output logic      req_ready_o,

    // Channel readies from the sinks
    input  logic      r_ready_i,
    input  logic      w_ready_i,

    // Global control
    input  logic      flush_i,
    input  logic      kill_i,

    // Status of the read splitter
    input  page_len_t r_bytes_to_pb_i,
    input  logic      r_done_i,
    input  logic      r_active_i,

    // Status of the write splitter
    input  page_len_t w_bytes_to_pb_i,
    input  logic      w_done_i,
    input  logic      w_active_i,

    // Channel valids
    output logic      r_valid_o,
    output logic      w_valid_o,

    // Splitter control
    output logic      r_advance_o,
    output logic      w_advance_o,
    output logic      load_o,
    output logic      clear_o,

    // Allowed bytes per side
    output page_len_t r_possible_o,
    output page_len_t w_possible_o
);

    // ------------------------------
    // Signals
    // ------------------------------
    rw_mode_e  mode_q;
    logic      decoupled;
    // Nearer of the two page boundaries
    page_len_t c_bytes_to_pb;
    // Handover condition per side, without kill
    logic      r_go;
    logic      w_go;

    assign decoupled = (mode_q == RW_DECOUPLED);

    // ------------------------------
    // Allowed bytes
    // ------------------------------
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ?
                           w_bytes_to_pb_i : r_bytes_to_pb_i;

    always_comb begin
        // Coupled: equal lengths on both sides
        r_possible_o = c_bytes_to_pb;
        w_possible_o = c_bytes_to_pb;
        if (decoupled) begin
            r_possible_o = r_bytes_to_pb_i;
            w_possible_o = w_bytes_to_pb_i;
        end
    end

    // ------------------------------
    // Flow control
    // ------------------------------
    always_comb begin
        if (decoupled) begin
            // Each side moves on its own ready
            r_go      = r_ready_i & ~flush_i;
            w_go      = w_ready_i & ~flush_i;
            r_valid_o = r_active_i & ~flush_i;
            w_valid_o = w_active_i & ~flush_i;
        end else begin
            // Pairs only, both readies needed
            r_go      = r_ready_i & w_ready_i & ~flush_i;
            w_go      = r_ready_i & w_ready_i & ~flush_i;
            r_valid_o = r_active_i & w_ready_i & ~flush_i;
            w_valid_o = w_active_i & r_ready_i & ~flush_i;
        end
    end

    // Kill also counts as an advance
    assign r_advance_o = r_go | kill_i;
    assign w_advance_o = w_go | kill_i;

    assign clear_o = kill_i;

    // Next transfer once both sides hand over their final burst
    // Kill frees both sides in the same cycle
    assign req_ready_o = (kill_i | (r_done_i & w_done_i))
                       & r_ready_i & w_ready_i & ~flush_i;

    assign load_o = req_valid_i & req_ready_o;

    // ------------------------------
    // Mode register
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode_q <= RW_COUPLED;
        end else if (load_o) begin
            mode_q <= req_decouple_i ? RW_DECOUPLED : RW_COUPLED;
        end
    end

endmodule

/* logic/idma_burst_splitter.sv */
// ------------------------------
// PageBytes must be a power of two from 64 to 4096
// Burst outputs are only meaningful while busy_o is high
// ------------------------------
`timescale 1ns/1ps

module idma_burst_splitter
    import idma_width_pkg::*;
    import idma_ctrl_pkg::*;
#(
    // Page size in bytes, no burst crosses it
    parameter int unsigned PageBytes = 256
) (
    input  logic      clk_i,
    input  logic      arst_n_i,

    // Start a new transfer, wins over everything else
    input  logic      load_i,
    // Current burst leaves, step to the next one
    input  logic      advance_i,
    // Drop the transfer at once
    input  logic      clear_i,

    // New transfer from the request side
    input  addr_t     start_addr_i,
    input  len_t      start_len_i,

    // Bytes this side may take in the current burst
    input  page_len_t possible_i,

    // Distance of the current address to the next page boundary
    output page_len_t bytes_to_pb_o,
    // Current burst is the final one, or nothing left
    output logic      done_o,

    // Current burst
    output addr_t     burst_addr_o,
    output page_len_t burst_len_o,

    // Transfer in progress
    output logic      busy_o
);

    // ------------------------------
    // Page geometry
    // ------------------------------
    // Low address bits that lie inside one page
    localparam addr_t PageMask = addr_t'(PageBytes - 1);
    // Full page as a page-relative count
    localparam page_len_t PageLen = page_len_t'(PageBytes);

    // ------------------------------
    // Signals
    // ------------------------------
    // Control state
    tf_state_e state_q;
    tf_state_e state_d;

    // Payload of the transfer, next byte address and bytes left
    addr_t     addr_q;
    addr_t     addr_d;
    len_t      len_q;
    len_t      len_d;

    // Offset of the current address inside its page
    addr_t     page_off;

    // Remaining bytes fit into the allowed size
    logic      fits;

    // Length of the burst offered now
    page_len_t burst_len;

    // ------------------------------
    // Boundary distance
    // ------------------------------
    // Power of two page, so a mask gives addr mod PageBytes
    assign page_off = addr_q & PageMask;

    // Never zero: an aligned address yields a full page
    assign bytes_to_pb_o = PageLen - page_len_t'(page_off);

    // ------------------------------
    // Current burst
    // ------------------------------
    // Compare at full length width so large transfers stay correct
    assign fits = (len_q <= len_t'(possible_i));

    // Final burst takes what is left, others take the allowed size
    // Truncation is safe here, len_q is at most one page when it fits
    assign burst_len = fits ? page_len_t'(len_q) : possible_i;

    assign burst_addr_o = addr_q;
    assign burst_len_o  = burst_len;

    // Idle counts as done so a new request can be taken
    assign done_o = (state_q == TF_IDLE) || fits;

    assign busy_o = (state_q == TF_ACTIVE);

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        // Hold by default, covers back-pressure and flush
        state_d = state_q;
        addr_d  = addr_q;
        len_d   = len_q;

        if (load_i) begin
            // Fresh transfer, first burst offered next cycle
            state_d = TF_ACTIVE;
            addr_d  = start_addr_i;
            len_d   = start_len_i;
        end else if (clear_i) begin
            // Kill, payload is left stale
            state_d = TF_IDLE;
        end else if (advance_i && (state_q == TF_ACTIVE)) begin
            // Step past the burst that was just handed over
            addr_d = addr_q + addr_t'(burst_len);
            len_d  = len_q - len_t'(burst_len);
            // Final burst gone
            if (fits) begin
                state_d = TF_IDLE;
            end
        end
    end

    // ------------------------------
    // Registers
    // ------------------------------
    // State machine
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TF_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Address and length
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
            len_q  <= '0;
        end else begin
            addr_q <= addr_d;
            len_q  <= len_d;
        end
    end

endmodule

/* logic/idma_ctrl_pkg.sv */
// ------------------------------
// Control encodings for the splitters and the coupler
// ------------------------------
package idma_ctrl_pkg;

    // ------------------------------
    // Splitter state
    // ------------------------------
    // Idle: no transfer held, no burst offered
    // Active: at least one burst still to emit
    typedef enum logic {
        TF_IDLE   = 1'b0,
        TF_ACTIVE = 1'b1
    } tf_state_e;

    // ------------------------------
    // Read/write coupling
    // ------------------------------
    // Coupled: both sides cut at the nearer page boundary
    // Decoupled: each side cuts at its own boundary
    typedef enum logic {
        RW_COUPLED   = 1'b0,
        RW_DECOUPLED = 1'b1
    } rw_mode_e;

endpackage

/* logic/idma_width_pkg.sv */
// ------------------------------
// Address, length and page count widths for the legalizer
// Page sizes above MaxPageBytes do not fit page_len_t
// ------------------------------
package idma_width_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    // Byte address width
    localparam int unsigned AddrWidth = 32;
    // Transfer length in bytes
    localparam int unsigned LenWidth = 32;
    // Largest legal page
    localparam int unsigned MaxPageBytes = 4096;
    // One extra bit so a full page fits
    localparam int unsigned PageLenWidth = $clog2(MaxPageBytes) + 1;

    // ------------------------------
    // Vector types
    // ------------------------------
    // Byte address on either side
    typedef logic [AddrWidth-1:0] addr_t;

    // Remaining bytes of a transfer
    typedef logic [LenWidth-1:0] len_t;

    // Byte count inside one page, up to a full page
    typedef logic [PageLenWidth-1:0] page_len_t;

endpackage
